// File: src/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_XLEN 32

// Register file geometry
`define CPU_REGS 32
`define CPU_REG_BITS 5

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Byte step between instructions
`define CPU_PC_STEP 32'd4

`endif

// File: src/cpuPkg.sv
package cpuPkg;

    // Control FSM states
    typedef enum logic [2:0] {
        Reset,
        Fetch,
        Decode,
        Execute,
        WriteBack
    } cpuState;

    typedef enum logic [5:0] {
        RType = 6'b000000,
        AddI  = 6'b001000
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        Sll  = 6'b000000,
        Srl  = 6'b000010,
        Sra  = 6'b000011,
        Sllv = 6'b000100,
        Srav = 6'b000111,
        Add  = 6'b100000,
        Sub  = 6'b100010,
        And  = 6'b100100,
        Slt  = 6'b101010
    } functT;

    typedef enum logic [1:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluSlt
    } aluOpT;

    typedef enum logic [1:0] {
        ShiftNone,
        ShiftLeft,
        ShiftRightLogic,
        ShiftRightArith
    } shiftOpT;

endpackage

// File: src/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::opcodeT  opcode,
    input  cpuPkg::functT   funct,
    input  logic            wbAck,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            irLoad,
    output logic            pcLoad,
    output logic            operandLoad,
    output logic            regWrite,
    output logic            retireValid,
    output logic            useImm,
    output logic            useVarShamt,
    output logic            resultFromShift,
    output logic            destIsRt,
    output cpuPkg::aluOpT   aluOp,
    output cpuPkg::shiftOpT shiftOp
);

    cpuPkg::cpuState state;
    cpuPkg::cpuState nextState;
    logic            writesReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuPkg::Reset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::Reset:     nextState = cpuPkg::Fetch;
            // Wait here until memory answers
            cpuPkg::Fetch:     nextState = wbAck ? cpuPkg::Decode : cpuPkg::Fetch;
            cpuPkg::Decode:    nextState = cpuPkg::Execute;
            cpuPkg::Execute:   nextState = cpuPkg::WriteBack;
            cpuPkg::WriteBack: nextState = cpuPkg::Fetch;
            default:           nextState = cpuPkg::Reset;
        endcase
    end

    // Bus and register strobes follow the state
    assign wbCyc       = (state == cpuPkg::Fetch);
    assign wbStb       = (state == cpuPkg::Fetch);
    assign irLoad      = (state == cpuPkg::Fetch) && wbAck;
    assign pcLoad      = (state == cpuPkg::Fetch) && wbAck;
    assign operandLoad = (state == cpuPkg::Decode);
    assign retireValid = (state == cpuPkg::WriteBack);
    assign regWrite    = (state == cpuPkg::WriteBack) && writesReg;

    // Decode table, unknown codes fall through with no write
    always_comb begin
        aluOp           = cpuPkg::AluAdd;
        shiftOp         = cpuPkg::ShiftNone;
        useImm          = 1'b0;
        useVarShamt     = 1'b0;
        resultFromShift = 1'b0;
        destIsRt        = 1'b0;
        writesReg       = 1'b0;
        case (opcode)
            cpuPkg::RType: begin
                writesReg = 1'b1;
                case (funct)
                    cpuPkg::Add: aluOp = cpuPkg::AluAdd;
                    cpuPkg::Sub: aluOp = cpuPkg::AluSub;
                    cpuPkg::And: aluOp = cpuPkg::AluAnd;
                    cpuPkg::Slt: aluOp = cpuPkg::AluSlt;
                    cpuPkg::Sll: begin
                        shiftOp         = cpuPkg::ShiftLeft;
                        resultFromShift = 1'b1;
                    end
                    cpuPkg::Srl: begin
                        shiftOp         = cpuPkg::ShiftRightLogic;
                        resultFromShift = 1'b1;
                    end
                    cpuPkg::Sra: begin
                        shiftOp         = cpuPkg::ShiftRightArith;
                        resultFromShift = 1'b1;
                    end
                    cpuPkg::Sllv: begin
                        shiftOp         = cpuPkg::ShiftLeft;
                        useVarShamt     = 1'b1;
                        resultFromShift = 1'b1;
                    end
                    cpuPkg::Srav: begin
                        shiftOp         = cpuPkg::ShiftRightArith;
                        useVarShamt     = 1'b1;
                        resultFromShift = 1'b1;
                    end
                    default: writesReg = 1'b0;
                endcase
            end
            cpuPkg::AddI: begin
                aluOp     = cpuPkg::AluAdd;
                useImm    = 1'b1;
                destIsRt  = 1'b1;
                writesReg = 1'b1;
            end
            default: writesReg = 1'b0;
        endcase
    end

    // Bus cycle ends right after the acknowledge
    cycleEndsOnAck: assert property (@(posedge clk) disable iff (reset)
        wbStb && wbAck |=> !wbCyc && !wbStb);

    // Request holds until acknowledged
    stbHeld: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb);

endmodule

// File: src/aluUnit.sv
`timescale 1ns/10ps

`include "cpuSettings.svh"

module aluUnit (
    input  logic [`CPU_XLEN-1:0] operandA,
    input  logic [`CPU_XLEN-1:0] operandB,
    input  cpuPkg::aluOpT        aluOp,
    output logic [`CPU_XLEN-1:0] result
);

    logic [`CPU_XLEN-1:0] sum;
    logic [`CPU_XLEN-1:0] difference;
    logic                 lessThan;

    assign sum        = operandA + operandB;
    assign difference = operandA - operandB;

    // Signed compare
    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            cpuPkg::AluAdd: result = sum;
            cpuPkg::AluSub: result = difference;
            cpuPkg::AluAnd: result = operandA & operandB;
            cpuPkg::AluSlt: result = {{(`CPU_XLEN-1){1'b0}}, lessThan};
            default:        result = sum;
        endcase
    end

endmodule

// File: src/shiftUnit.sv
`timescale 1ns/10ps

`include "cpuSettings.svh"

module shiftUnit (
    input  logic [`CPU_XLEN-1:0] value,
    input  logic [4:0]           shamt,
    input  logic [`CPU_XLEN-1:0] varAmount,
    input  logic                 useVarShamt,
    input  cpuPkg::shiftOpT      shiftOp,
    output logic [`CPU_XLEN-1:0] result
);

    logic [4:0] amount;

    // Only the low five bits of rs count
    assign amount = useVarShamt ? varAmount[4:0] : shamt;

    always_comb begin
        case (shiftOp)
            cpuPkg::ShiftLeft:       result = value << amount;
            cpuPkg::ShiftRightLogic: result = value >> amount;
            cpuPkg::ShiftRightArith: result = $unsigned($signed(value) >>> amount);
            default:                 result = value;
        endcase
    end

endmodule

// File: src/registerFile.sv
`timescale 1ns/10ps

`include "cpuSettings.svh"

module registerFile (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     writeEnable,
    input  logic [`CPU_REG_BITS-1:0] readAddrA,
    input  logic [`CPU_REG_BITS-1:0] readAddrB,
    input  logic [`CPU_REG_BITS-1:0] writeAddr,
    input  logic [`CPU_XLEN-1:0]     writeData,
    output logic [`CPU_XLEN-1:0]     readDataA,
    output logic [`CPU_XLEN-1:0]     readDataB
);

    logic [`CPU_XLEN-1:0] regs [0:`CPU_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register 0 is never written so it reads back zero
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    zeroRegA: assert property (@(posedge clk) disable iff (reset)
        (readAddrA == '0) |-> (readDataA == '0));

    zeroRegB: assert property (@(posedge clk) disable iff (reset)
        (readAddrB == '0) |-> (readDataB == '0));

endmodule

// File: src/cpuTop.sv
`timescale 1ns/10ps

`include "cpuSettings.svh"

module cpuTop (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wbAck,
    input  logic [`CPU_XLEN-1:0]     wbDatI,
    output logic                     wbCyc,
    output logic                     wbStb,
    output logic                     wbWe,
    output logic [`CPU_XLEN-1:0]     wbAdr,
    output logic                     retireValid,
    output logic [`CPU_REG_BITS-1:0] retireReg,
    output logic [`CPU_XLEN-1:0]     retireData
);

    logic [`CPU_XLEN-1:0]     pc;
    logic [`CPU_XLEN-1:0]     ir;
    logic [`CPU_XLEN-1:0]     regA;
    logic [`CPU_XLEN-1:0]     regB;
    logic [`CPU_XLEN-1:0]     resultReg;
    logic [`CPU_XLEN-1:0]     readDataA;
    logic [`CPU_XLEN-1:0]     readDataB;
    logic [`CPU_XLEN-1:0]     immExt;
    logic [`CPU_XLEN-1:0]     aluB;
    logic [`CPU_XLEN-1:0]     aluResult;
    logic [`CPU_XLEN-1:0]     shiftResult;
    logic [`CPU_REG_BITS-1:0] destReg;
    logic                     irLoad;
    logic                     pcLoad;
    logic                     operandLoad;
    logic                     regWrite;
    logic                     useImm;
    logic                     useVarShamt;
    logic                     resultFromShift;
    logic                     destIsRt;
    cpuPkg::aluOpT            aluOp;
    cpuPkg::shiftOpT          shiftOp;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (pcLoad) begin
            pc <= pc + `CPU_PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (irLoad) begin
            ir <= wbDatI;
        end
        if (operandLoad) begin
            regA <= readDataA;
            regB <= readDataB;
        end
        // Stays stable through WriteBack since A, B and IR hold
        resultReg <= resultFromShift ? shiftResult : aluResult;
    end

    assign wbAdr = pc;
    assign wbWe  = 1'b0;

    assign immExt  = {{16{ir[15]}}, ir[15:0]};
    assign aluB    = useImm ? immExt : regB;
    assign destReg = destIsRt ? ir[20:16] : ir[15:11];

    // Trace port
    assign retireReg  = regWrite ? destReg : '0;
    assign retireData = resultReg;

    controlUnit ctrl0 (
        .clk             (clk),
        .reset           (reset),
        .opcode          (cpuPkg::opcodeT'(ir[31:26])),
        .funct           (cpuPkg::functT'(ir[5:0])),
        .wbAck           (wbAck),
        .wbCyc           (wbCyc),
        .wbStb           (wbStb),
        .irLoad          (irLoad),
        .pcLoad          (pcLoad),
        .operandLoad     (operandLoad),
        .regWrite        (regWrite),
        .retireValid     (retireValid),
        .useImm          (useImm),
        .useVarShamt     (useVarShamt),
        .resultFromShift (resultFromShift),
        .destIsRt        (destIsRt),
        .aluOp           (aluOp),
        .shiftOp         (shiftOp)
    );

    aluUnit alu0 (
        .operandA (regA),
        .operandB (aluB),
        .aluOp    (aluOp),
        .result   (aluResult)
    );

    // rt is shifted, rs gives the variable amount
    shiftUnit shift0 (
        .value       (regB),
        .shamt       (ir[10:6]),
        .varAmount   (regA),
        .useVarShamt (useVarShamt),
        .shiftOp     (shiftOp),
        .result      (shiftResult)
    );

    registerFile regs0 (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (regWrite),
        .readAddrA   (ir[25:21]),
        .readAddrB   (ir[20:16]),
        .writeAddr   (destReg),
        .writeData   (resultReg),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    // Address comes from the PC, which must not move during a wait
    adrHeld: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> $stable(wbAdr));

endmodule

// File: verification/cpuTb.sv
`timescale 1ns/10ps

`include "cpuSettings.svh"

module cpuTb;

    localparam int clkPeriod = 20;
    localparam int progLen = 19;
    localparam int watchdogNs = progLen * (3 + 5) * clkPeriod + 2 * clkPeriod;

    // MIPS encodings
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddI = 6'h08;
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnSlt = 6'h2A;

    logic        clk = 1'b0;
    logic        reset;
    logic        wbAck;
    logic [31:0] wbDatI;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic        retireValid;
    logic [4:0]  retireReg;
    logic [31:0] retireData;

    logic [31:0] progMem [0:progLen-1];
    logic [31:0] mirrorRegs [0:31];
    logic [15:0] lfsrState = 16'd64;
    logic        requestSeen = 1'b0;
    int          waitLeft = 0;
    logic [31:0] expPc = `CPU_RESET_PC;
    logic [4:0]  expReg = 5'd0;
    logic [31:0] expData = 32'd0;
    int          retireCountdown = 0;
    int          retiredCount = 0;
    logic        prevWaiting = 1'b0;
    logic [31:0] prevAdr = 32'd0;

    cpuTop dut0 (
        .clk         (clk),
        .reset       (reset),
        .wbAck       (wbAck),
        .wbDatI      (wbDatI),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, expected);
        abortRun();
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        abortRun();
    endtask

    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawWaitStates(output int count);
        count = 0;
        repeat (2) begin
            count = (count << 1) | lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [4:0] shamt,
                                            input logic [5:0] funct);
        return {opRType, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encodeAddI(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [15:0] imm);
        return {opAddI, rs, rt, imm};
    endfunction

    // Executes one word on the mirror and gives the expected trace
    task automatic runMirror(input logic [31:0] word, output logic [4:0] destReg,
                             output logic [31:0] value);
        logic [4:0]  rt;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        rt = word[20:16];
        shamt = word[10:6];
        a = mirrorRegs[word[25:21]];
        b = mirrorRegs[rt];
        destReg = 5'd0;
        value = 32'd0;
        if (word[31:26] == opAddI) begin
            destReg = rt;
            value = a + {{16{word[15]}}, word[15:0]};
        end else if (word[31:26] == opRType) begin
            destReg = word[15:11];
            case (word[5:0])
                fnAdd:   value = a + b;
                fnSub:   value = a - b;
                fnAnd:   value = a & b;
                fnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnSll:   value = b << shamt;
                fnSrl:   value = b >> shamt;
                fnSra:   value = $signed(b) >>> shamt;
                fnSllv:  value = b << a[4:0];
                fnSrav:  value = $signed(b) >>> a[4:0];
                default: destReg = 5'd0;
            endcase
        end
        if (destReg != 5'd0) begin
            mirrorRegs[destReg] = value;
        end
    endtask

    // Wishbone memory with 0 to 3 wait states per fetch
    always @(negedge clk) begin
        if (reset || wbAck) begin
            wbAck = 1'b0;
            requestSeen = 1'b0;
        end else if (wbStb && ((wbAdr >> 2) < progLen)) begin
            if (!requestSeen) begin
                requestSeen = 1'b1;
                drawWaitStates(waitLeft);
            end
            if (waitLeft == 0) begin
                wbAck = 1'b1;
                wbDatI = progMem[wbAdr >> 2];
            end else begin
                waitLeft--;
            end
        end
    end

    always @(posedge clk) begin
        logic [4:0]  destReg;
        logic [31:0] value;
        if (!reset) begin
            assert (!wbWe) else reportMismatch("wbWe", wbWe, 32'd0);
            assert (!wbStb || wbCyc) else reportFailure("wbStb was high without wbCyc");
            if (prevWaiting) begin
                assert (wbStb) else reportFailure("wbStb dropped during a wait state");
                assert (wbAdr == prevAdr) else reportMismatch("wbAdr", wbAdr, prevAdr);
            end
            if (wbStb) begin
                assert (wbAdr == expPc) else reportMismatch("wbAdr", wbAdr, expPc);
            end
            assert (retireValid == (retireCountdown == 1))
                else reportMismatch("retireValid", retireValid, retireCountdown == 1);
            if (retireCountdown == 1) begin
                assert (retireReg == expReg) else reportMismatch("retireReg", retireReg, expReg);
                if (expReg != 5'd0) begin
                    assert (retireData == expData)
                        else reportMismatch("retireData", retireData, expData);
                end
                retiredCount++;
            end
            prevWaiting = wbStb && !wbAck;
            prevAdr = wbAdr;
            // Retire is due 3 cycles after the ack cycle
            if (wbStb && wbAck) begin
                runMirror(wbDatI, destReg, value);
                expReg = destReg;
                expData = value;
                expPc = expPc + `CPU_PC_STEP;
                retireCountdown = 3;
            end else if (retireCountdown != 0) begin
                retireCountdown--;
            end
        end
    end

    initial begin
        #(watchdogNs);
        reportFailure("Watchdog expired before the program retired");
    end

    initial begin
        reset = 1'b1;
        wbAck = 1'b0;
        wbDatI = 32'd0;
        for (int i = 0; i < 32; i++) begin
            mirrorRegs[i] = 32'd0;
        end
        progMem[0] = encodeAddI(5'd0, 5'd1, 16'd100);
        progMem[1] = encodeAddI(5'd0, 5'd2, 16'hFFF9);
        progMem[2] = encodeR(5'd1, 5'd2, 5'd3, 5'd0, fnAdd);
        progMem[3] = encodeR(5'd2, 5'd1, 5'd4, 5'd0, fnSub);
        progMem[4] = encodeR(5'd1, 5'd2, 5'd5, 5'd0, fnAnd);
        progMem[5] = encodeR(5'd2, 5'd1, 5'd6, 5'd0, fnSlt);
        progMem[6] = encodeR(5'd1, 5'd2, 5'd7, 5'd0, fnSlt);
        progMem[7] = encodeR(5'd0, 5'd1, 5'd8, 5'd4, fnSll);
        progMem[8] = encodeR(5'd0, 5'd2, 5'd9, 5'd3, fnSrl);
        progMem[9] = encodeR(5'd0, 5'd2, 5'd10, 5'd3, fnSra);
        progMem[10] = encodeAddI(5'd0, 5'd11, 16'd5);
        progMem[11] = encodeR(5'd11, 5'd1, 5'd12, 5'd0, fnSllv);
        progMem[12] = encodeR(5'd11, 5'd2, 5'd13, 5'd0, fnSrav);
        progMem[13] = encodeR(5'd11, 5'd1, 5'd14, 5'd0, fnSrav);
        // Write to r0, then read it back
        progMem[14] = encodeAddI(5'd1, 5'd0, 16'd55);
        progMem[15] = encodeR(5'd0, 5'd1, 5'd15, 5'd0, fnAdd);
        progMem[16] = encodeR(5'd1, 5'd2, 5'd16, 5'd0, 6'h3F);
        progMem[17] = encodeR(5'd1, 5'd1, 5'd16, 5'd0, fnAdd);
        progMem[18] = encodeR(5'd0, 5'd2, 5'd17, 5'd0, fnSub);
        repeat (2) @(negedge clk);
        reset = 1'b0;
        assert (!wbCyc && !wbStb && !retireValid)
            else reportFailure("Bus or trace active right after reset");
        assert (wbAdr == `CPU_RESET_PC) else reportMismatch("wbAdr", wbAdr, `CPU_RESET_PC);
        wait (retiredCount == progLen);
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/cpuPkg.sv
src/controlUnit.sv
src/aluUnit.sv
src/shiftUnit.sv
src/registerFile.sv
src/cpuTop.sv
verification/cpuTb.sv

// File: Bender.yml
package:
  name: mipsMulticycle

export_include_dirs:
  - src

sources:
  - src/cpuPkg.sv
  - src/controlUnit.sv
  - src/aluUnit.sv
  - src/shiftUnit.sv
  - src/registerFile.sv
  - src/cpuTop.sv
  - target: test
    files:
      - verification/cpuTb.sv
